/* Bender.yml */
package:
  name: accCpu

sources:
  - src/cpuPkg.sv
  - src/alu.sv
  - src/cpuRegs.sv
  - src/wbMaster.sv
  - src/cpuCtrl.sv
  - src/cpuTop.sv
  - target: test
    files:
      - verif/tbMemModel.sv
      - verif/tbCpu.sv

/* all.f */
src/cpuPkg.sv
src/alu.sv
src/cpuRegs.sv
src/wbMaster.sv
src/cpuCtrl.sv
src/cpuTop.sv
verif/tbMemModel.sv
verif/tbCpu.sv

/* src/alu.sv */
//*************************************************
// ALU for the accumulator CPU
// Function select from opcode and control state,
// then the arithmetic and logic operations
//*************************************************

`timescale 1ns/1ps

module alu
(
  input  logic [cpuPkg::dataWidth-1:0]   srcA,
  input  logic [cpuPkg::dataWidth-1:0]   srcB,
  input  logic [cpuPkg::opcodeWidth-1:0] opCode,
  input  cpuPkg::cpuState                currentState,
  output logic [cpuPkg::dataWidth-1:0]   aluOut
);

  cpuPkg::aluFunc funcSel;

  // Fetch always bumps the PC, other states follow the opcode
  always_comb
  begin
    if (currentState == cpuPkg::InstrFetch)
    begin
      funcSel = cpuPkg::fnIncB;
    end
    else
    begin
      case (opCode)
        cpuPkg::opLda: funcSel = cpuPkg::fnPassB;
        cpuPkg::opSto: funcSel = cpuPkg::fnAdd;
        cpuPkg::opAdd: funcSel = cpuPkg::fnAdd;
        cpuPkg::opSub: funcSel = cpuPkg::fnSub;
        cpuPkg::opJmp: funcSel = cpuPkg::fnPassB;
        cpuPkg::opJge: funcSel = cpuPkg::fnPassB;
        cpuPkg::opJne: funcSel = cpuPkg::fnPassB;
        cpuPkg::opStp: funcSel = cpuPkg::fnPassB;
        cpuPkg::opShr: funcSel = cpuPkg::fnShtR;
        cpuPkg::opShl: funcSel = cpuPkg::fnShtL;
        cpuPkg::opAnd: funcSel = cpuPkg::fnAnd;
        cpuPkg::opOr:  funcSel = cpuPkg::fnOr;
        cpuPkg::opXor: funcSel = cpuPkg::fnXor;
        cpuPkg::opCom: funcSel = cpuPkg::fnCom;
        cpuPkg::opSwp: funcSel = cpuPkg::fnSwp;
        default:       funcSel = cpuPkg::fnNop;
      endcase
    end
  end

  always_comb
  begin
    case (funcSel)
      cpuPkg::fnAdd:   aluOut = srcA + srcB;
      cpuPkg::fnSub:   aluOut = srcA - srcB;
      cpuPkg::fnPassB: aluOut = srcB;
      cpuPkg::fnIncB:  aluOut = srcB + 1'b1;
      // Shifts act on the accumulator only
      cpuPkg::fnShtR:  aluOut = srcA >> 1;
      cpuPkg::fnShtL:  aluOut = srcA << 1;
      cpuPkg::fnAnd:   aluOut = srcA & srcB;
      cpuPkg::fnOr:    aluOut = srcA | srcB;
      cpuPkg::fnXor:   aluOut = srcA ^ srcB;
      cpuPkg::fnCom:   aluOut = ~srcB;
      cpuPkg::fnSwp:   aluOut = {srcB[15:0], srcB[31:16]};
      default:         aluOut = srcB;
    endcase
  end

endmodule

/* src/cpuCtrl.sv */
//*************************************************
// Control FSM of the accumulator CPU
// Fetch, execute, operand read, store and halt,
// plus branch decision and bus address choice
//*************************************************

`timescale 1ns/1ps

module cpuCtrl
(
  input  logic                         clk,
  input  logic                         rstN,
  input  cpuPkg::busWord               ir,
  input  logic [cpuPkg::addrWidth-1:0] pc,
  input  logic [cpuPkg::dataWidth-1:0] acc,
  input  logic                         busDone,
  output logic                         busReq,
  output logic                         busWe,
  output logic [cpuPkg::addrWidth-1:0] busAdr,
  output logic                         pcLoad,
  output logic                         irLoad,
  output logic                         accLoad,
  output logic [1:0]                   srcBSel,
  output cpuPkg::cpuState              currentState,
  output logic                         halted
);

  cpuPkg::cpuState                 nextState;
  logic [cpuPkg::opcodeWidth-1:0]  opCode;
  logic                            takeBranch;

  assign opCode = ir.instr.opCode;

  // JGE tests the sign bit, JNE tests for a nonzero accumulator
  always_comb
  begin
    case (opCode)
      cpuPkg::opJmp: takeBranch = 1'b1;
      cpuPkg::opJge: takeBranch = !acc[cpuPkg::dataWidth-1];
      cpuPkg::opJne: takeBranch = (acc != '0);
      default:       takeBranch = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      currentState <= cpuPkg::Init;
    end
    else
    begin
      currentState <= nextState;
    end
  end

  always_comb
  begin
    nextState = currentState;
    busReq    = 1'b0;
    busWe     = 1'b0;
    busAdr    = ir.instr.addr;
    pcLoad    = 1'b0;
    irLoad    = 1'b0;
    accLoad   = 1'b0;
    srcBSel   = cpuPkg::selRdData;
    case (currentState)
      cpuPkg::Init:
      begin
        nextState = cpuPkg::InstrFetch;
      end
      cpuPkg::InstrFetch:
      begin
        busAdr  = pc;
        busReq  = !busDone;
        srcBSel = cpuPkg::selPc;
        if (busDone)
        begin
          irLoad    = 1'b1;
          pcLoad    = 1'b1;
          nextState = cpuPkg::InstrExec;
        end
      end
      cpuPkg::InstrExec:
      begin
        srcBSel   = cpuPkg::selIrAddr;
        nextState = cpuPkg::InstrFetch;
        case (opCode)
          cpuPkg::opLda, cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
          cpuPkg::opOr, cpuPkg::opXor, cpuPkg::opCom, cpuPkg::opSwp:
            nextState = cpuPkg::OperandRead;
          cpuPkg::opSto: nextState = cpuPkg::StoreWrite;
          cpuPkg::opStp: nextState = cpuPkg::Halted;
          cpuPkg::opShr, cpuPkg::opShl: accLoad = 1'b1;
          cpuPkg::opJmp, cpuPkg::opJge, cpuPkg::opJne: pcLoad = takeBranch;
          default: nextState = cpuPkg::InstrFetch;
        endcase
      end
      cpuPkg::OperandRead:
      begin
        busReq  = !busDone;
        accLoad = busDone;
        if (busDone)
        begin
          nextState = cpuPkg::InstrFetch;
        end
      end
      cpuPkg::StoreWrite:
      begin
        busReq = !busDone;
        busWe  = 1'b1;
        if (busDone)
        begin
          nextState = cpuPkg::InstrFetch;
        end
      end
      default:
      begin
        nextState = cpuPkg::Halted;
      end
    endcase
  end

  assign halted = (currentState == cpuPkg::Halted);

  // Halt is final and the bus stays quiet from then on
  haltQuiet: assert property (@(posedge clk) disable iff (!rstN)
    halted |=> (halted && !busReq));

endmodule

/* src/cpuPkg.sv */
//*************************************************
// Shared definitions for the accumulator CPU
// Word widths, opcode values, control states,
// ALU function codes, srcB select codes and the
// bus read word union
//*************************************************

package cpuPkg;

  localparam int dataWidth   = 32;
  localparam int opcodeWidth = 8;
  localparam int addrWidth   = 12;

  // Instruction set
  localparam logic [opcodeWidth-1:0] opLda = 8'h0;
  localparam logic [opcodeWidth-1:0] opSto = 8'h1;
  localparam logic [opcodeWidth-1:0] opAdd = 8'h2;
  localparam logic [opcodeWidth-1:0] opSub = 8'h3;
  localparam logic [opcodeWidth-1:0] opJmp = 8'h4;
  localparam logic [opcodeWidth-1:0] opJge = 8'h5;
  localparam logic [opcodeWidth-1:0] opJne = 8'h6;
  localparam logic [opcodeWidth-1:0] opStp = 8'h7;
  localparam logic [opcodeWidth-1:0] opShr = 8'h8;
  localparam logic [opcodeWidth-1:0] opShl = 8'h9;
  localparam logic [opcodeWidth-1:0] opAnd = 8'ha;
  localparam logic [opcodeWidth-1:0] opOr  = 8'hb;
  localparam logic [opcodeWidth-1:0] opXor = 8'hc;
  localparam logic [opcodeWidth-1:0] opCom = 8'hd;
  localparam logic [opcodeWidth-1:0] opSwp = 8'he;
  localparam logic [opcodeWidth-1:0] opNop = 8'hf;

  // srcB mux select codes
  localparam logic [1:0] selPc     = 2'd0;
  localparam logic [1:0] selIrAddr = 2'd1;
  localparam logic [1:0] selRdData = 2'd2;

  typedef enum logic [2:0] {
    Init, InstrFetch, InstrExec, OperandRead, StoreWrite, Halted
  } cpuState;

  typedef enum logic [3:0] {
    fnAdd, fnSub, fnPassB, fnIncB, fnShtR, fnShtL,
    fnAnd, fnOr, fnXor, fnCom, fnSwp, fnNop
  } aluFunc;

  // Opcode in the top byte, word address in the low bits
  typedef struct packed {
    logic [opcodeWidth-1:0]                     opCode;
    logic [dataWidth-opcodeWidth-addrWidth-1:0] spare;
    logic [addrWidth-1:0]                       addr;
  } instrFields;

  typedef union packed {
    instrFields           instr;
    logic [dataWidth-1:0] data;
  } busWord;

endpackage

/* src/cpuRegs.sv */
//*************************************************
// Architectural registers of the accumulator CPU
// Program counter, instruction register and
// accumulator, each with its own load enable
//*************************************************

`timescale 1ns/1ps

module cpuRegs
(
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           pcLoad,
  input  logic                           irLoad,
  input  logic                           accLoad,
  input  logic [cpuPkg::dataWidth-1:0]   aluOut,
  input  cpuPkg::busWord                 rdWord,
  output logic [cpuPkg::addrWidth-1:0]   pc,
  output cpuPkg::busWord                 ir,
  output logic [cpuPkg::dataWidth-1:0]   acc
);

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      pc  <= '0;
      ir  <= '0;
      acc <= '0;
    end
    else
    begin
      // PC is a word address, upper ALU bits drop off
      if (pcLoad)
      begin
        pc <= aluOut[cpuPkg::addrWidth-1:0];
      end
      if (irLoad)
      begin
        ir <= rdWord;
      end
      if (accLoad)
      begin
        acc <= aluOut;
      end
    end
  end

endmodule

/* src/cpuTop.sv */
//*************************************************
// Accumulator CPU top level
// Control FSM, registers, ALU, Wishbone master
// and the srcB operand mux
//*************************************************

`timescale 1ns/1ps

module cpuTop
(
  input  logic                         clk,
  input  logic                         rstN,
  output logic                         wbCyc,
  output logic                         wbStb,
  output logic                         wbWe,
  output logic [cpuPkg::addrWidth-1:0] wbAdr,
  output logic [cpuPkg::dataWidth-1:0] wbDatO,
  input  logic [cpuPkg::dataWidth-1:0] wbDatI,
  input  logic                         wbAck,
  output logic                         halted
);

  logic                         busReq;
  logic                         busWe;
  logic [cpuPkg::addrWidth-1:0] busAdr;
  logic                         busDone;
  cpuPkg::busWord               rdWord;
  logic                         pcLoad;
  logic                         irLoad;
  logic                         accLoad;
  logic [1:0]                   srcBSel;
  cpuPkg::cpuState              currentState;
  logic [cpuPkg::addrWidth-1:0] pc;
  cpuPkg::busWord               ir;
  logic [cpuPkg::dataWidth-1:0] acc;
  logic [cpuPkg::dataWidth-1:0] srcB;
  logic [cpuPkg::dataWidth-1:0] aluOut;

  // Addresses are zero extended to a full word
  always_comb
  begin
    case (srcBSel)
      cpuPkg::selPc:     srcB = {{(cpuPkg::dataWidth-cpuPkg::addrWidth){1'b0}}, pc};
      cpuPkg::selIrAddr: srcB = {{(cpuPkg::dataWidth-cpuPkg::addrWidth){1'b0}}, ir.instr.addr};
      default:           srcB = rdWord.data;
    endcase
  end

  cpuCtrl uCtrl
  (
    .clk(clk), .rstN(rstN), .ir(ir), .pc(pc), .acc(acc), .busDone(busDone),
    .busReq(busReq), .busWe(busWe), .busAdr(busAdr), .pcLoad(pcLoad),
    .irLoad(irLoad), .accLoad(accLoad), .srcBSel(srcBSel),
    .currentState(currentState), .halted(halted)
  );

  cpuRegs uRegs
  (
    .clk(clk), .rstN(rstN), .pcLoad(pcLoad), .irLoad(irLoad), .accLoad(accLoad),
    .aluOut(aluOut), .rdWord(rdWord), .pc(pc), .ir(ir), .acc(acc)
  );

  alu uAlu
  (
    .srcA(acc), .srcB(srcB), .opCode(ir.instr.opCode),
    .currentState(currentState), .aluOut(aluOut)
  );

  wbMaster uBus
  (
    .clk(clk), .rstN(rstN), .busReq(busReq), .busWe(busWe), .busAdr(busAdr),
    .wrData(acc), .busDone(busDone), .rdWord(rdWord), .wbCyc(wbCyc),
    .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
    .wbDatI(wbDatI), .wbAck(wbAck)
  );

endmodule

/* src/wbMaster.sv */
//*************************************************
// Wishbone classic master sequencer
// Holds one request until ack, captures read data
// and pulses busDone after the ack edge
//*************************************************

`timescale 1ns/1ps

module wbMaster
(
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         busReq,
  input  logic                         busWe,
  input  logic [cpuPkg::addrWidth-1:0] busAdr,
  input  logic [cpuPkg::dataWidth-1:0] wrData,
  output logic                         busDone,
  output cpuPkg::busWord               rdWord,
  output logic                         wbCyc,
  output logic                         wbStb,
  output logic                         wbWe,
  output logic [cpuPkg::addrWidth-1:0] wbAdr,
  output logic [cpuPkg::dataWidth-1:0] wbDatO,
  input  logic [cpuPkg::dataWidth-1:0] wbDatI,
  input  logic                         wbAck
);

  logic startReq;

  // New request only accepted when no cycle is open
  assign startReq = busReq && !wbCyc;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      wbCyc   <= 1'b0;
      wbStb   <= 1'b0;
      wbWe    <= 1'b0;
      busDone <= 1'b0;
    end
    else
    begin
      busDone <= 1'b0;
      if (wbCyc && wbAck)
      begin
        wbCyc   <= 1'b0;
        wbStb   <= 1'b0;
        wbWe    <= 1'b0;
        busDone <= 1'b1;
      end
      else if (startReq)
      begin
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe  <= busWe;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (startReq)
    begin
      wbAdr  <= busAdr;
      wbDatO <= wrData;
    end
    if (wbCyc && wbAck && !wbWe)
    begin
      rdWord.data <= wbDatI;
    end
  end

  stbInsideCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc);

  // Address frozen while the slave is stalling
  adrStable: assert property (@(posedge clk) disable iff (!rstN)
    (wbStb && !wbAck) |=> $stable(wbAdr));

endmodule

/* verif/cpuTrace.txt */
# P addr word = program image word, W addr data = expected store in order
# H addr = address of the STP instruction, all values in hex
P 000 00000040
P 001 01000080
P 002 02000041
P 003 01000081
P 004 03000042
P 005 01000082
P 006 0a000043
P 007 01000083
P 008 0b000042
P 009 01000084
P 00a 0c000043
P 00b 01000085
P 00c 08000000
P 00d 01000086
P 00e 09000000
P 00f 01000087
P 010 0d000041
P 011 01000088
P 012 0e000040
P 013 01000089
P 014 0f000000
P 015 0100008a
P 016 00000044
P 017 0600001a
P 018 00000046
P 019 0400001b
P 01a 00000045
P 01b 0100008b
P 01c 0600001f
P 01d 00000045
P 01e 04000020
P 01f 00000047
P 020 0100008c
P 021 05000024
P 022 00000045
P 023 04000025
P 024 00000048
P 025 0100008d
P 026 05000029
P 027 00000049
P 028 0400002a
P 029 00000045
P 02a 0100008e
P 02b 07000000
P 040 12345678
P 041 00001111
P 042 0f0f0f0f
P 043 ff0000ff
P 044 00000000
P 045 bad0bad0
P 046 00000601
P 047 00000602
P 048 80000503
P 049 00000504
W 080 12345678
W 081 12346789
W 082 0325587a
W 083 0300007a
W 084 0f0f0f7f
W 085 f00f0f80
W 086 780787c0
W 087 f00f0f80
W 088 ffffeeee
W 089 56781234
W 08a 56781234
W 08b 00000601
W 08c 00000602
W 08d 80000503
W 08e 00000504
H 02b

/* verif/tbCpu.sv */
//*************************************************
// Testbench for the accumulator CPU
// Clock and reset, trace reader, bus monitor with
// handshake, store and halt checks, cycle limit
//*************************************************

`timescale 1ns/1ps

module tbCpu;

  logic                         clk = 1'b0;
  logic                         rstN;
  logic                         wbCyc;
  logic                         wbStb;
  logic                         wbWe;
  logic [cpuPkg::addrWidth-1:0] wbAdr;
  logic [cpuPkg::dataWidth-1:0] wbDatO;
  logic [cpuPkg::dataWidth-1:0] wbDatI;
  logic                         wbAck;
  logic                         halted;

  // Expected stores in program order
  logic [cpuPkg::addrWidth-1:0] expAdrQ [$];
  logic [cpuPkg::dataWidth-1:0] expDatQ [$];
  logic [cpuPkg::addrWidth-1:0] haltAdr;
  logic [cpuPkg::addrWidth-1:0] lastReadAdr = '0;
  int                           progLines = 0;
  int                           storesExpected = 0;
  int                           storesSeen = 0;
  int                           cycleCount = 0;
  int                           cycleLimit = 200;

  // Bus request currently being watched
  logic                         reqOpen = 1'b0;
  logic                         reqWe = 1'b0;
  logic                         firstReq = 1'b1;
  logic [cpuPkg::addrWidth-1:0] reqAdr = '0;
  logic [cpuPkg::dataWidth-1:0] reqDat = '0;

  initial
  begin
    forever #10 clk = ~clk;
  end

  cpuTop UUT
  (
    .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
    .wbAdr(wbAdr), .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck), .halted(halted)
  );

  tbMemModel uMem
  (
    .clk(clk), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck)
  );

  task automatic endWithFailure();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkAddr(input string name, input logic [cpuPkg::addrWidth-1:0] got,
                           input logic [cpuPkg::addrWidth-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      endWithFailure();
    end
  endtask

  task automatic checkData(input string name, input logic [cpuPkg::dataWidth-1:0] got,
                           input logic [cpuPkg::dataWidth-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      endWithFailure();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      endWithFailure();
    end
  endtask

  task automatic readTrace();
    int                           fd;
    int                           n;
    logic [7:0]                   kind;
    logic [cpuPkg::addrWidth-1:0] adr;
    logic [cpuPkg::dataWidth-1:0] word;
    logic [8*160-1:0]             rest;
    logic                         done;
    logic                         haltGiven;
    fd = $fopen("verif/cpuTrace.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the trace file verif/cpuTrace.txt");
      endWithFailure();
    end
    done      = 1'b0;
    haltGiven = 1'b0;
    while (!done)
    begin
      n = $fscanf(fd, " %c", kind);
      if (n != 1)
      begin
        done = 1'b1;
      end
      else if (kind == "#")
      begin
        n = $fgets(rest, fd);
      end
      else if (kind == "P" || kind == "W")
      begin
        n = $fscanf(fd, "%h %h", adr, word);
        if (n != 2)
        begin
          $display("A trace line of kind %c is missing its address or word", kind);
          endWithFailure();
        end
        if (kind == "P")
        begin
          uMem.writeWord(adr, word);
          progLines++;
        end
        else
        begin
          expAdrQ.push_back(adr);
          expDatQ.push_back(word);
        end
      end
      else if (kind == "H")
      begin
        n = $fscanf(fd, "%h", haltAdr);
        haltGiven = (n == 1);
      end
      else
      begin
        $display("The trace holds a line of unknown kind %c", kind);
        endWithFailure();
      end
    end
    $fclose(fd);
    if (!haltGiven)
    begin
      $display("The trace gives no halt address");
      endWithFailure();
    end
    storesExpected = expAdrQ.size();
    // Each program word allows three transfers of up to four cycles
    cycleLimit = progLines * 4 * 3 + 200;
  endtask

  task automatic checkStore();
    if (expAdrQ.size() == 0)
    begin
      $display("The CPU stored to 0x%h after all expected stores were done", reqAdr);
      endWithFailure();
    end
    checkAddr("store wbAdr", reqAdr, expAdrQ.pop_front());
    checkData("store wbDatO", reqDat, expDatQ.pop_front());
    storesSeen++;
  endtask

  // Sampled on the falling edge, where the master outputs are settled
  task automatic watchBus();
    // Strobe rises and falls together with the cycle
    checkFlag("wbStb", wbStb, wbCyc);
    if (wbCyc && wbStb)
    begin
      if (!reqOpen)
      begin
        reqOpen = 1'b1;
        reqAdr  = wbAdr;
        reqDat  = wbDatO;
        reqWe   = wbWe;
        if (firstReq)
        begin
          checkAddr("first fetch wbAdr", wbAdr, '0);
          checkFlag("first fetch wbWe", wbWe, 1'b0);
          firstReq = 1'b0;
        end
      end
      else
      begin
        checkAddr("held wbAdr", wbAdr, reqAdr);
        checkData("held wbDatO", wbDatO, reqDat);
        checkFlag("held wbWe", wbWe, reqWe);
      end
    end
    else if (reqOpen)
    begin
      // Cycle closed, so the ack was taken on the last rising edge
      reqOpen = 1'b0;
      if (reqWe)
      begin
        checkStore();
      end
      else
      begin
        lastReadAdr = reqAdr;
      end
    end
  endtask

  initial
  begin
    forever
    begin
      @(negedge clk);
      watchBus();
    end
  end

  initial
  begin
    forever
    begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount > cycleLimit)
      begin
        $display("Timeout: the CPU did not halt within %0d cycles", cycleLimit);
        endWithFailure();
      end
    end
  end

  initial
  begin
    rstN = 1'b0;
    uMem.fillMemory();
    readTrace();
    repeat (16) @(negedge clk);
    checkFlag("wbCyc in reset", wbCyc, 1'b0);
    checkFlag("wbStb in reset", wbStb, 1'b0);
    checkFlag("halted in reset", halted, 1'b0);
    rstN = 1'b1;
    while (!halted)
    begin
      @(negedge clk);
    end
    // Bus must stay idle once halted
    repeat (20)
    begin
      @(negedge clk);
      checkFlag("wbCyc after halt", wbCyc, 1'b0);
      checkFlag("halted after halt", halted, 1'b1);
    end
    checkAddr("halt fetch wbAdr", lastReadAdr, haltAdr);
    if (storesSeen != storesExpected)
    begin
      $display("Only %0d of %0d expected stores happened", storesSeen, storesExpected);
      endWithFailure();
    end
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

/* verif/tbMemModel.sv */
//*************************************************
// Wishbone classic memory slave for the testbench
// Random wait states before each ack, fill and
// load tasks for the program image
//*************************************************

`timescale 1ns/1ps

module tbMemModel
(
  input  logic                         clk,
  input  logic                         wbCyc,
  input  logic                         wbStb,
  input  logic                         wbWe,
  input  logic [cpuPkg::addrWidth-1:0] wbAdr,
  input  logic [cpuPkg::dataWidth-1:0] wbDatO,
  output logic [cpuPkg::dataWidth-1:0] wbDatI,
  output logic                         wbAck
);

  localparam logic [31:0] rngSeed  = 32'h0b488900;
  localparam int          memWords = 1 << cpuPkg::addrWidth;

  logic [cpuPkg::dataWidth-1:0] mem [0:memWords-1];
  logic                         busy;
  int                           waitLeft;

  // Unloaded words read as NOPs tagged with their own address
  task automatic fillMemory();
    logic [cpuPkg::addrWidth-1:0] adr;
    for (int i = 0; i < memWords; i++)
    begin
      adr    = i;
      mem[i] = {cpuPkg::opNop, 12'h000, adr};
    end
  endtask

  task automatic writeWord(input logic [cpuPkg::addrWidth-1:0] adr,
                           input logic [cpuPkg::dataWidth-1:0] word);
    mem[adr] = word;
  endtask

  // Slave runs on the falling edge, the master samples on the rising one
  initial
  begin
    void'($urandom(rngSeed));
    wbAck    = 1'b0;
    wbDatI   = '0;
    busy     = 1'b0;
    waitLeft = 0;
    forever
    begin
      @(negedge clk);
      if (wbAck)
      begin
        wbAck = 1'b0;
      end
      else if (wbCyc && wbStb)
      begin
        if (!busy)
        begin
          waitLeft = $urandom % 4;
          busy     = 1'b1;
        end
        if (waitLeft == 0)
        begin
          if (wbWe)
          begin
            mem[wbAdr] = wbDatO;
          end
          else
          begin
            wbDatI = mem[wbAdr];
          end
          wbAck = 1'b1;
          busy  = 1'b0;
        end
        else
        begin
          waitLeft--;
        end
      end
    end
  end

endmodule
